// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_dcache
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Test completed successfully
VFLAGS    ?= --binary --timing --assert

SOURCES := $(wildcard include/*.svh src/*.sv sim/*.sv)
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# the simulator status is ignored, the log decides
run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) && echo "PASS" || (echo "FAIL"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: all.f
+incdir+include
src/dcache_pkg.sv
src/sram_2p.sv
src/dcache_write_arb.sv
src/dcache_read_arb.sv
src/mmio_regs.sv
src/dcache_top.sv
sim/tb_dcache.sv

// File: include/dcache_cfg.svh
`ifndef DCACHE_CFG_SVH
`define DCACHE_CFG_SVH

// cache geometry
`define CACHE_SIZE_E 13
`define CASSOC 2
`define CBANKS 2
`define CWIDTH 2

// field widths of the cache word address
`define CWAY_W $clog2(`CASSOC)
`define CBANK_W $clog2(`CBANKS)
`define CWORD_W $clog2(`CWIDTH)
`define CADDR_W (`CACHE_SIZE_E - 2)
`define CROW_W (`CADDR_W - `CWAY_W - `CBANK_W - `CWORD_W)
`define CROWS (1 << `CROW_W)

// byte address within one way, as the core sees it
`define CBYTE_AW (`CADDR_W - `CWAY_W + 2)

// mmio register offsets
`define MMIO_POWER_OFF 0
`define MMIO_REBOOT 4

`endif

// File: sim/tb_dcache.sv
`timescale 1ns/1ps

`include "dcache_cfg.svh"

module tb_dcache import dcache_pkg::*; ();

    // about 600 cycles of tests, with a wide margin
    localparam int MAX_CYCLES  = 3000;
    localparam int REGION_ROWS = 16;

    logic                clk;
    logic                rst_n;
    core_wr_t            core_wr;
    core_rd_t            core_rd;
    mem_port_t           memc_wr;
    mem_port_t           memc_rd;
    logic                mmio_we;
    logic                mmio_re;
    logic [3:0]          mmio_addr;
    logic [31:0]         mmio_wdata;
    ways_data_t          core_rdata;
    row_data_t           memc_rdata;
    logic                wbusy;
    logic                rbusy;
    logic [`CBANK_W-1:0] rbusy_bank;
    logic [31:0]         mmio_rdata;
    logic                power_off;
    logic                reboot;

    // expected contents, one word per cache word address
    logic [31:0] model_mem [1 << `CADDR_W];
    logic [31:0] rng_state = 32'h5437_7a54;
    int          cycle_count;

    dcache_top dut (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        cycle_count = 0;
        forever begin
            @(posedge clk);
            cycle_count++;
            if (cycle_count >= MAX_CYCLES) begin
                report_failure($sformatf("timeout: run did not finish in %0d cycles", MAX_CYCLES));
            end
        end
    end

    function automatic logic [31:0] lcg_next();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    function automatic cache_addr_u make_addr(int way, int row, int bank, int word);
        cache_addr_u a;
        a.f.way  = way[`CWAY_W-1:0];
        a.f.row  = row[`CROW_W-1:0];
        a.f.bank = bank[`CBANK_W-1:0];
        a.f.word = word[`CWORD_W-1:0];
        return a;
    endfunction

    // upper lcg bits only, the low ones repeat quickly
    function automatic cache_addr_u rand_addr();
        logic [31:0] r;
        r = lcg_next();
        return make_addr(int'(r[31]), int'(r[27:20]) % REGION_ROWS, int'(r[30]), int'(r[29]));
    endfunction

    function automatic logic [`CBYTE_AW-1:0] byte_addr(cache_addr_u a);
        return {a.f.row, a.f.bank, a.f.word, 2'b00};
    endfunction

    // core sees the same word slot of every way
    function automatic ways_data_t expect_ways(cache_addr_u a);
        ways_data_t  w;
        cache_addr_u idx;
        idx = a;
        for (int i = 0; i < `CASSOC; i++) begin
            idx.f.way = i[`CWAY_W-1:0];
            w[i] = model_mem[idx.raw];
        end
        return w;
    endfunction

    function automatic row_data_t expect_row(cache_addr_u a);
        row_data_t   r;
        cache_addr_u idx;
        idx = a;
        for (int i = 0; i < `CWIDTH; i++) begin
            idx.f.word = i[`CWORD_W-1:0];
            r[i] = model_mem[idx.raw];
        end
        return r;
    endfunction

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_ways(input ways_data_t got, input ways_data_t exp, input string what);
        if (got !== exp) begin
            report_failure($sformatf("[FAIL] %0d ns: %s got %h expected %h",
                                     $time, what, got, exp));
        end
    endtask

    task automatic check_row(input row_data_t got, input row_data_t exp, input string what);
        if (got !== exp) begin
            report_failure($sformatf("[FAIL] %0d ns: %s got %h expected %h",
                                     $time, what, got, exp));
        end
    endtask

    task automatic check_word(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            report_failure($sformatf("[FAIL] %0d ns: %s got %h expected %h",
                                     $time, what, got, exp));
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            report_failure($sformatf("[FAIL] %0d ns: %s got %b expected %b",
                                     $time, what, got, exp));
        end
    endtask

    task automatic step();
        @(posedge clk);
        #2;
    endtask

    task automatic idle_writes();
        core_wr = '0;
        memc_wr = '0;
        memc_wr.ce_n = 1'b1;
        memc_wr.we_n = 1'b1;
    endtask

    task automatic idle_reads();
        core_rd = '0;
        memc_rd = '0;
        memc_rd.ce_n = 1'b1;
        memc_rd.we_n = 1'b1;
    endtask

    task automatic drive_fill(input cache_addr_u a, input row_data_t d,
                              input logic [4*`CWIDTH-1:0] wm);
        cache_addr_u idx;
        memc_wr.ce_n = 1'b0;
        memc_wr.we_n = 1'b0;
        memc_wr.addr = a;
        memc_wr.data = d;
        memc_wr.wm   = wm;
        idx = a;
        for (int w = 0; w < `CWIDTH; w++) begin
            idx.f.word = w[`CWORD_W-1:0];
            for (int b = 0; b < 4; b++) begin
                if (wm[4*w + b]) begin
                    model_mem[idx.raw][8*b +: 8] = d[w][8*b +: 8];
                end
            end
        end
    endtask

    // kept is low when a fill on the same bank drops the store
    task automatic drive_store(input cache_addr_u a, input logic [31:0] data,
                               input logic [3:0] mask, input bit kept);
        core_wr.en   = 1'b1;
        core_wr.way  = a.f.way;
        core_wr.addr = byte_addr(a);
        core_wr.data = data;
        core_wr.mask = mask;
        for (int b = 0; b < 4; b++) begin
            if (kept && mask[b]) begin
                model_mem[a.raw][8*b +: 8] = data[8*b +: 8];
            end
        end
    endtask

    task automatic fill_full(input cache_addr_u a);
        drive_fill(a, {lcg_next(), lcg_next()}, '1);
        step();
        idle_writes();
    endtask

    task automatic read_check(input bit core_en, input cache_addr_u ca,
                              input bit memc_en, input cache_addr_u ma);
        ways_data_t exp_w;
        row_data_t  exp_r;
        bit         core_valid;
        exp_w = expect_ways(ca);
        exp_r = expect_row(ma);
        core_valid = core_en && !(memc_en && ca.f.bank == ma.f.bank);
        core_rd.en   = core_en;
        core_rd.addr = byte_addr(ca);
        memc_rd      = '0;
        memc_rd.ce_n = !memc_en;
        memc_rd.we_n = 1'b1;
        memc_rd.addr = ma;
        #1;
        check_bit(rbusy, memc_en, "rbusy");
        if (memc_en) begin
            check_bit(rbusy_bank, ma.f.bank, "rbusy_bank");
        end else begin
            check_bit(rbusy_bank, 1'b0, "rbusy_bank idle");
        end
        step();
        idle_reads();
        step();
        if (core_valid) begin
            check_ways(core_rdata, exp_w, "core_rdata");
        end
        if (memc_en) begin
            check_row(memc_rdata, exp_r, "memc_rdata");
        end
    endtask

    task automatic test_mmio();
        check_bit(power_off, 1'b0, "power_off after reset");
        check_bit(reboot, 1'b0, "reboot after reset");
        mmio_we    = 1'b1;
        mmio_addr  = 4'(`MMIO_REBOOT);
        mmio_wdata = 32'd1;
        step();
        mmio_we = 1'b0;
        check_bit(reboot, 1'b1, "reboot pulse");
        step();
        check_bit(reboot, 1'b0, "reboot pulse end");
        mmio_we   = 1'b1;
        mmio_addr = 4'(`MMIO_POWER_OFF);
        step();
        mmio_we = 1'b0;
        check_bit(power_off, 1'b1, "power_off set");
        mmio_re = 1'b1;
        step();
        mmio_re = 1'b0;
        check_word(mmio_rdata, 32'd1, "power_off read-back");
        mmio_re   = 1'b1;
        mmio_addr = 4'(`MMIO_REBOOT);
        step();
        mmio_re = 1'b0;
        check_word(mmio_rdata, 32'd0, "reboot read-back");
        step();
        check_bit(power_off, 1'b1, "power_off sticky");
    endtask

    // rows 3 and 200 of every way and bank
    task automatic test_fill_read();
        for (int i = 0; i < 8; i++) begin
            fill_full(make_addr(i & 1, (i < 4) ? 3 : 200, (i >> 1) & 1, 0));
        end
        for (int i = 0; i < 8; i++) begin
            read_check(1'b0, '0, 1'b1, make_addr(i & 1, (i < 4) ? 3 : 200, (i >> 1) & 1, 0));
        end
    endtask

    task automatic test_core_store();
        drive_store(make_addr(1, 3, 0, 1), 32'hdead_beef, 4'b0110, 1'b1);
        step();
        idle_writes();
        read_check(1'b1, make_addr(1, 3, 0, 1), 1'b0, '0);
        read_check(1'b0, '0, 1'b1, make_addr(1, 3, 0, 0));
        drive_store(make_addr(0, 200, 1, 0), 32'h1234_5678, 4'b1001, 1'b1);
        step();
        idle_writes();
        read_check(1'b1, make_addr(0, 200, 1, 0), 1'b0, '0);
    endtask

    task automatic test_write_conflict();
        for (int i = 0; i < 6; i++) begin
            fill_full(make_addr(i & 1, (i < 2) ? 5 : 6, (i < 2) ? 1 : (i >> 2), 0));
        end
        // same bank, fill wins
        drive_fill(make_addr(0, 5, 1, 0), {lcg_next(), lcg_next()}, '1);
        drive_store(make_addr(1, 5, 1, 0), lcg_next(), 4'hf, 1'b0);
        #1;
        check_bit(wbusy, 1'b1, "wbusy on same bank");
        step();
        idle_writes();
        read_check(1'b1, make_addr(0, 5, 1, 0), 1'b0, '0);
        drive_fill(make_addr(1, 6, 0, 0), {lcg_next(), lcg_next()}, '1);
        drive_store(make_addr(0, 6, 1, 1), lcg_next(), 4'hf, 1'b1);
        #1;
        check_bit(wbusy, 1'b0, "wbusy on different banks");
        step();
        idle_writes();
        read_check(1'b1, make_addr(0, 6, 1, 1), 1'b1, make_addr(1, 6, 0, 0));
    endtask

    task automatic test_read_conflict();
        read_check(1'b1, make_addr(0, 3, 0, 1), 1'b1, make_addr(1, 3, 0, 0));
        read_check(1'b1, make_addr(0, 200, 1, 0), 1'b1, make_addr(0, 3, 0, 0));
    endtask

    task automatic test_random_traffic();
        cache_addr_u fa;
        cache_addr_u sa;
        logic [31:0] r;
        bit          do_fill;
        bit          do_store;
        bit          same_bank;
        for (int i = 0; i < 4 * REGION_ROWS; i++) begin
            fill_full(make_addr(i & 1, i >> 2, (i >> 1) & 1, 0));
        end
        for (int i = 0; i < 200; i++) begin
            r = lcg_next();
            fa = rand_addr();
            sa = rand_addr();
            do_fill   = r[31:30] != 2'd1;
            do_store  = r[31:30] != 2'd0;
            same_bank = do_fill && do_store && fa.f.bank == sa.f.bank;
            if (do_fill) begin
                drive_fill(fa, {lcg_next(), lcg_next()}, r[23:16]);
            end
            if (do_store) begin
                drive_store(sa, lcg_next(), r[27:24], !same_bank);
            end
            #1;
            check_bit(wbusy, same_bank, "wbusy in random traffic");
            step();
            idle_writes();
        end
        for (int i = 0; i < 100; i++) begin
            r = lcg_next();
            read_check(r[31:30] != 2'd1, rand_addr(), r[31:30] != 2'd0, rand_addr());
        end
    endtask

    initial begin
        rst_n      = 1'b0;
        mmio_we    = 1'b0;
        mmio_re    = 1'b0;
        mmio_addr  = '0;
        mmio_wdata = '0;
        idle_writes();
        idle_reads();
        repeat (3) @(posedge clk);
        #2;
        rst_n = 1'b1;
        step();
        test_mmio();
        test_fill_read();
        test_core_store();
        test_write_conflict();
        test_read_conflict();
        test_random_traffic();
        $display("Test completed successfully");
        $finish;
    end

endmodule

// File: src/dcache_pkg.sv
`include "dcache_cfg.svh"

package dcache_pkg;

    // word address, either compared as a whole or split into fields
    typedef union packed {
        logic [`CADDR_W-1:0] raw;
        struct packed {
            logic [`CWAY_W-1:0]  way;
            logic [`CROW_W-1:0]  row;
            logic [`CBANK_W-1:0] bank;
            logic [`CWORD_W-1:0] word;
        } f;
    } cache_addr_u;

    // one bank row, CWIDTH words
    typedef logic [`CWIDTH-1:0][31:0] row_data_t;

    // core read result, one word per way
    typedef logic [`CASSOC-1:0][31:0] ways_data_t;

    // full bank output, all ways and all words
    typedef logic [`CASSOC-1:0][`CWIDTH-1:0][31:0] bank_data_t;

    // one access on a bank port, strobes active low
    typedef struct packed {
        logic                  ce_n;
        logic                  we_n;
        cache_addr_u           addr;
        row_data_t             data;
        logic [4*`CWIDTH-1:0]  wm;
    } bank_port_t;

    // memory controller drives the same shape as a bank port
    typedef bank_port_t mem_port_t;

    // core store, one word with byte mask
    typedef struct packed {
        logic                  en;
        logic [`CWAY_W-1:0]    way;
        logic [`CBYTE_AW-1:0]  addr;
        logic [31:0]           data;
        logic [3:0]            mask;
    } core_wr_t;

    // core load, all ways are read at once
    typedef struct packed {
        logic                  en;
        logic [`CBYTE_AW-1:0]  addr;
    } core_rd_t;

endpackage

// File: src/dcache_read_arb.sv
`timescale 1ns/1ps

`include "dcache_cfg.svh"

module dcache_read_arb import dcache_pkg::*; (
    input  logic                        clk,
    input  logic                        rst_n,

    input  core_rd_t                    core_rd,
    input  mem_port_t                   memc_rd,

    output bank_port_t [`CBANKS-1:0]    bank_rd,
    input  bank_data_t [`CBANKS-1:0]    bank_rdata,

    output ways_data_t                  core_rdata,
    output row_data_t                   memc_rdata,
    output logic                        rbusy,
    output logic [`CBANK_W-1:0]         rbusy_bank
);

    cache_addr_u core_addr;
    cache_addr_u core_raddr_q [2];
    cache_addr_u memc_raddr_q [2];

    // way bits do not matter, the whole row holds every way
    assign core_addr.raw = {(`CWAY_W)'(0), core_rd.addr[`CBYTE_AW-1:2]};

    always_comb begin
        for (int b = 0; b < `CBANKS; b++) begin
            bank_rd[b]      = '0;
            bank_rd[b].ce_n = 1'b1;
            bank_rd[b].we_n = 1'b1;
        end
        if (core_rd.en) begin
            bank_rd[core_addr.f.bank].ce_n = 1'b0;
            bank_rd[core_addr.f.bank].addr = core_addr;
        end
        // memory controller overrides the core on its bank
        if (!memc_rd.ce_n) begin
            bank_rd[memc_rd.addr.f.bank] = memc_rd;
        end
    end

    assign rbusy      = !memc_rd.ce_n;
    assign rbusy_bank = rbusy ? memc_rd.addr.f.bank : '0;

    // addresses follow the two memory stages
    always_ff @(posedge clk) begin
        core_raddr_q[0] <= core_addr;
        core_raddr_q[1] <= core_raddr_q[0];
        memc_raddr_q[0] <= memc_rd.addr;
        memc_raddr_q[1] <= memc_raddr_q[0];
    end

    // core gets one word slot from each way
    always_comb begin
        for (int a = 0; a < `CASSOC; a++) begin
            core_rdata[a] = bank_rdata[core_raddr_q[1].f.bank][a][core_raddr_q[1].f.word];
        end
    end

    // memory controller gets the full row of one way
    assign memc_rdata = bank_rdata[memc_raddr_q[1].f.bank][memc_raddr_q[1].f.way];

    a_memc_rd_is_read: assert property (
        @(posedge clk) disable iff (!rst_n)
        !memc_rd.ce_n |-> memc_rd.we_n
    );

endmodule

// File: src/dcache_top.sv
`timescale 1ns/1ps

`include "dcache_cfg.svh"

module dcache_top import dcache_pkg::*; (
    input  logic                clk,
    input  logic                rst_n,

    input  core_wr_t            core_wr,
    input  core_rd_t            core_rd,
    output ways_data_t          core_rdata,
    output logic                wbusy,
    output logic                rbusy,
    output logic [`CBANK_W-1:0] rbusy_bank,

    input  mem_port_t           memc_wr,
    input  mem_port_t           memc_rd,
    output row_data_t           memc_rdata,

    input  logic                mmio_we,
    input  logic                mmio_re,
    input  logic [3:0]          mmio_addr,
    input  logic [31:0]         mmio_wdata,
    output logic [31:0]         mmio_rdata,
    output logic                power_off,
    output logic                reboot
);

    bank_port_t [`CBANKS-1:0] bank_wr;
    bank_port_t [`CBANKS-1:0] bank_rd;
    bank_data_t [`CBANKS-1:0] bank_rdata;

    dcache_write_arb u_write_arb (
        .clk     (clk),
        .rst_n   (rst_n),
        .core_wr (core_wr),
        .memc_wr (memc_wr),
        .bank_wr (bank_wr),
        .wbusy   (wbusy)
    );

    dcache_read_arb u_read_arb (
        .clk        (clk),
        .rst_n      (rst_n),
        .core_rd    (core_rd),
        .memc_rd    (memc_rd),
        .bank_rd    (bank_rd),
        .bank_rdata (bank_rdata),
        .core_rdata (core_rdata),
        .memc_rdata (memc_rdata),
        .rbusy      (rbusy),
        .rbusy_bank (rbusy_bank)
    );

    // one memory per bank, ways side by side in a row
    for (genvar i = 0; i < `CBANKS; i++) begin : g_bank
        sram_2p #(
            .DATA_W (32 * `CASSOC * `CWIDTH),
            .DEPTH  (`CROWS),
            .MASK_W (4 * `CASSOC * `CWIDTH)
        ) u_sram (
            .clk    (clk),
            .ce0_n  (bank_wr[i].ce_n),
            .we0_n  (bank_wr[i].we_n),
            .addr0  (bank_wr[i].addr.f.row),
            .wdata0 ({`CASSOC{bank_wr[i].data}}),
            .wm0    ((4*`CASSOC*`CWIDTH)'(bank_wr[i].wm) << (bank_wr[i].addr.f.way * 4*`CWIDTH)),
            .rdata0 (),
            .ce1_n  (bank_rd[i].ce_n),
            .addr1  (bank_rd[i].addr.f.row),
            .rdata1 (bank_rdata[i])
        );
    end

    mmio_regs u_mmio (
        .clk        (clk),
        .rst_n      (rst_n),
        .mmio_we    (mmio_we),
        .mmio_re    (mmio_re),
        .mmio_addr  (mmio_addr),
        .mmio_wdata (mmio_wdata),
        .mmio_rdata (mmio_rdata),
        .power_off  (power_off),
        .reboot     (reboot)
    );

endmodule

// File: src/dcache_write_arb.sv
`timescale 1ns/1ps

`include "dcache_cfg.svh"

module dcache_write_arb import dcache_pkg::*; (
    input  logic                        clk,
    input  logic                        rst_n,

    input  core_wr_t                    core_wr,
    input  mem_port_t                   memc_wr,

    output bank_port_t [`CBANKS-1:0]    bank_wr,
    output logic                        wbusy
);

    bank_port_t core_port;

    // core store widened to a full row
    always_comb begin
        core_port      = '0;
        core_port.ce_n = !core_wr.en;
        core_port.we_n = !core_wr.en;
        core_port.addr.raw = {core_wr.way, core_wr.addr[`CBYTE_AW-1:2]};
        core_port.data = {`CWIDTH{core_wr.data}};
        core_port.wm   = (4*`CWIDTH)'(core_wr.mask) << (core_port.addr.f.word * 4);
    end

    // fill is placed last so it wins its bank
    always_comb begin
        for (int b = 0; b < `CBANKS; b++) begin
            bank_wr[b]      = '0;
            bank_wr[b].ce_n = 1'b1;
            bank_wr[b].we_n = 1'b1;
        end
        if (!core_port.ce_n) begin
            bank_wr[core_port.addr.f.bank] = core_port;
        end
        if (!memc_wr.ce_n) begin
            bank_wr[memc_wr.addr.f.bank] = memc_wr;
        end
    end

    // store dropped, core has to retry
    assign wbusy = !memc_wr.ce_n && !core_port.ce_n &&
                   (memc_wr.addr.f.bank == core_port.addr.f.bank);

    // write ports never carry a read
    for (genvar b = 0; b < `CBANKS; b++) begin : g_chk
        a_wr_only: assert property (
            @(posedge clk) disable iff (!rst_n)
            !bank_wr[b].ce_n |-> !bank_wr[b].we_n
        );
    end

endmodule

// File: src/mmio_regs.sv
`timescale 1ns/1ps

`include "dcache_cfg.svh"

module mmio_regs (
    input  logic        clk,
    input  logic        rst_n,

    input  logic        mmio_we,
    input  logic        mmio_re,
    input  logic [3:0]  mmio_addr,
    input  logic [31:0] mmio_wdata,
    output logic [31:0] mmio_rdata,

    output logic        power_off,
    output logic        reboot
);

    logic power_off_wr;
    logic reboot_wr;

    assign power_off_wr = mmio_we && (mmio_addr == 4'(`MMIO_POWER_OFF)) && (mmio_wdata != '0);
    assign reboot_wr    = mmio_we && (mmio_addr == 4'(`MMIO_REBOOT)) && (mmio_wdata != '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            power_off  <= 1'b0;
            reboot     <= 1'b0;
            mmio_rdata <= '0;
        end else begin
            // sticky until reset
            if (power_off_wr) begin
                power_off <= 1'b1;
            end
            reboot <= reboot_wr;
            if (mmio_re) begin
                mmio_rdata <= (mmio_addr == 4'(`MMIO_POWER_OFF)) ? 32'(power_off) : '0;
            end
        end
    end

    // software issues one reboot write, never back to back
    a_reboot_pulse: assert property (
        @(posedge clk) disable iff (!rst_n)
        reboot |=> !reboot
    );

endmodule

// File: src/sram_2p.sv
`timescale 1ns/1ps

module sram_2p #(
    parameter int DATA_W = 128,
    parameter int DEPTH  = 256,
    parameter int MASK_W = 16
) (
    input  logic                       clk,

    input  logic                       ce0_n,
    input  logic                       we0_n,
    input  logic [$clog2(DEPTH)-1:0]   addr0,
    input  logic [DATA_W-1:0]          wdata0,
    input  logic [MASK_W-1:0]          wm0,
    output logic [DATA_W-1:0]          rdata0,

    input  logic                       ce1_n,
    input  logic [$clog2(DEPTH)-1:0]   addr1,
    output logic [DATA_W-1:0]          rdata1
);

    localparam int LANE_W = DATA_W / MASK_W;

    logic [DATA_W-1:0] mem [DEPTH];
    logic [DATA_W-1:0] rd0_q;
    logic [DATA_W-1:0] rd1_q;

    // array is sampled at the request edge, so a same-cycle write is not seen
    always_ff @(posedge clk) begin
        if (!ce0_n && !we0_n) begin
            for (int i = 0; i < MASK_W; i++) begin
                if (wm0[i]) begin
                    mem[addr0][i*LANE_W +: LANE_W] <= wdata0[i*LANE_W +: LANE_W];
                end
            end
        end
        if (!ce0_n && we0_n) begin
            rd0_q <= mem[addr0];
        end
        if (!ce1_n) begin
            rd1_q <= mem[addr1];
        end
    end

    // output stage, second cycle of latency
    always_ff @(posedge clk) begin
        rdata0 <= rd0_q;
        rdata1 <= rd1_q;
    end

    a_addr0_known: assert property (@(posedge clk) !ce0_n |-> !$isunknown(addr0));
    a_addr1_known: assert property (@(posedge clk) !ce1_n |-> !$isunknown(addr1));

endmodule
